/* logic/openadc_pkg.sv */
`default_nettype none

package openadc_pkg;

   // host bus
   localparam int unsigned APB_ADDR_W = 8;
   localparam int unsigned APB_DATA_W = 32;

   // register map, byte addresses
   localparam logic [APB_ADDR_W-1:0] GAIN_ADDR              = 8'h00;
   localparam logic [APB_ADDR_W-1:0] SETTINGS_ADDR          = 8'h04;
   localparam logic [APB_ADDR_W-1:0] ECHO_ADDR              = 8'h08;
   localparam logic [APB_ADDR_W-1:0] SAMPLES_ADDR           = 8'h0C;
   localparam logic [APB_ADDR_W-1:0] PRESAMPLES_ADDR        = 8'h10;
   localparam logic [APB_ADDR_W-1:0] OFFSET_ADDR            = 8'h14;
   localparam logic [APB_ADDR_W-1:0] DECIMATE_ADDR          = 8'h18;
   localparam logic [APB_ADDR_W-1:0] ADC_TRIG_LEVEL_ADDR    = 8'h1C;
   localparam logic [APB_ADDR_W-1:0] MAX_SAMPLES_ADDR       = 8'h20; // read only
   localparam logic [APB_ADDR_W-1:0] NUM_TRIGGERS_DATA_ADDR = 8'h24;
   localparam logic [APB_ADDR_W-1:0] NUM_TRIGGERS_STAT_ADDR = 8'h28;

   // settings byte, trigger mode and trigger wait set out of reset
   localparam logic [7:0] SETTINGS_RESET = 8'h24;

   localparam int unsigned SET_TRIG_MODE_BIT = 2;
   localparam int unsigned SET_ARM_BIT       = 3;
   localparam int unsigned SET_STREAM_BIT    = 4;
   localparam int unsigned SET_TRIG_WAIT_BIT = 5;
   localparam int unsigned SET_TRIG_NOW_BIT  = 6;

   // field widths
   localparam int unsigned GAIN_W       = 8;
   localparam int unsigned TRIG_LEVEL_W = 12;
   localparam int unsigned PRESAMPLES_W = 15;
   localparam int unsigned DOWNSAMPLE_W = 13;
   localparam int unsigned SAMPLES_W    = 32;

   // capture buffer limit, also the sample count after reset
   localparam logic [SAMPLES_W-1:0] MAX_SAMPLES = 32'd24576;

   // trigger interval log
   localparam int unsigned TRIG_FIFO_WIDTH = 32;
   localparam int unsigned TRIG_FIFO_DEPTH = 8;

endpackage

`default_nettype wire

/* logic/trig_interval_fifo.sv */
`default_nettype none

module trig_interval_fifo import openadc_pkg::*; #(
   parameter int unsigned depth_p = TRIG_FIFO_DEPTH // power of two
) (
   input  wire                        adc_sampleclk,
   input  wire                        reset,
   input  wire                        push_i,
   input  wire  [TRIG_FIFO_WIDTH-1:0] push_data_i,
   input  wire                        pop_i,
   input  wire                        flush_pop_i,
   input  wire                        clear_i,
   output logic [TRIG_FIFO_WIDTH-1:0] rdata_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       underflow_o
);

   localparam int unsigned ptr_w = $clog2(depth_p);
   localparam logic [ptr_w:0] full_cnt = depth_p[ptr_w:0];

   logic [TRIG_FIFO_WIDTH-1:0] mem_q [depth_p];
   logic [ptr_w-1:0]           wr_ptr_q;
   logic [ptr_w-1:0]           rd_ptr_q;
   logic [ptr_w:0]             count_q;
   logic                       pop;
   logic                       do_wr;
   logic                       do_rd;

   assign pop     = pop_i | flush_pop_i;
   assign full_o  = (count_q == full_cnt);
   assign empty_o = (count_q == '0);
   assign do_wr   = push_i & ~full_o;
   assign do_rd   = pop & ~empty_o;

   always_ff @(posedge adc_sampleclk) begin
      if (do_wr)
         mem_q[wr_ptr_q] <= push_data_i;
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_wr && !do_rd)
            count_q <= count_q + 1'b1;
         else if (do_rd && !do_wr)
            count_q <= count_q - 1'b1;
      end
   end

   // head is read out on pop and held until the next one
   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         rdata_o     <= '0;
         underflow_o <= 1'b0;
      end else begin
         if (do_rd)
            rdata_o <= mem_q[rd_ptr_q];
         if (clear_i)
            underflow_o <= 1'b0;
         else if (pop && empty_o)
            underflow_o <= 1'b1; // sticky until host clears
      end
   end

endmodule

`default_nettype wire

/* logic/trig_interval_logger.sv */
`default_nettype none

module trig_interval_logger import openadc_pkg::*; (
   input  wire                        adc_sampleclk,
   input  wire                        reset,
   input  wire                        trigger_event_i,
   input  wire                        arm_i,
   input  wire                        fifo_clear_i,
   input  wire                        fifo_full_i,
   input  wire                        fifo_empty_i,
   output logic                       push_o,
   output logic [TRIG_FIFO_WIDTH-1:0] push_data_o,
   output logic                       flush_pop_o,
   output logic                       overflow_o
);

   logic [TRIG_FIFO_WIDTH-1:0] count_q;
   logic                       arm_q;
   logic                       flush_q;
   logic                       arm_rise;

   // cycles since last event, sticks at all ones
   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         count_q <= '0;
      end else if (trigger_event_i) begin
         count_q <= '0;
      end else if (~&count_q) begin
         count_q <= count_q + 1'b1;
      end
   end

   assign push_o      = trigger_event_i & ~fifo_full_i;
   assign push_data_o = count_q;

   // event lost to a full fifo
   always_ff @(posedge adc_sampleclk) begin
      if (reset || fifo_clear_i) begin
         overflow_o <= 1'b0;
      end else if (trigger_event_i && fifo_full_i) begin
         overflow_o <= 1'b1;
      end
   end

   assign arm_rise = arm_i & ~arm_q;

   // drain old intervals when a new capture is armed
   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         arm_q   <= 1'b0;
         flush_q <= 1'b0;
      end else begin
         arm_q <= arm_i;
         if (fifo_empty_i)
            flush_q <= 1'b0;
         else if (arm_rise)
            flush_q <= 1'b1;
      end
   end

   assign flush_pop_o = flush_q & ~fifo_empty_i;

endmodule

`default_nettype wire

/* logic/openadc_reg_apb.sv */
`default_nettype none

module openadc_reg_apb import openadc_pkg::*; (
   input  wire                        adc_sampleclk,
   input  wire                        reset,
   // apb slave
   input  wire                        psel_i,
   input  wire                        penable_i,
   input  wire                        pwrite_i,
   input  wire  [APB_ADDR_W-1:0]      paddr_i,
   input  wire  [APB_DATA_W-1:0]      pwdata_i,
   output logic [APB_DATA_W-1:0]      prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   // trigger interval fifo
   input  wire  [TRIG_FIFO_WIDTH-1:0] fifo_rdata_i,
   input  wire                        fifo_empty_i,
   input  wire                        fifo_overflow_i,
   input  wire                        fifo_underflow_i,
   output logic                       fifo_pop_o,
   output logic                       fifo_clear_o,
   // capture controls
   output logic [GAIN_W-1:0]          gain_o,
   output logic                       trigger_mode_o,
   output logic                       cmd_arm_o,
   output logic                       fifo_stream_o,
   output logic                       trigger_wait_o,
   output logic                       trigger_now_o,
   output logic [APB_DATA_W-1:0]      trigger_offset_o,
   output logic [TRIG_LEVEL_W-1:0]    trigger_adclevel_o,
   output logic [SAMPLES_W-1:0]       maxsamples_o,
   output logic [PRESAMPLES_W-1:0]    presamples_o,
   output logic [DOWNSAMPLE_W-1:0]    downsample_o
);

   logic [GAIN_W-1:0]       gain_q;
   logic [7:0]              settings_q;
   logic [APB_DATA_W-1:0]   echo_q;
   logic [SAMPLES_W-1:0]    samples_q;
   logic [PRESAMPLES_W-1:0] presamples_q;
   logic [APB_DATA_W-1:0]   offset_q;
   logic [DOWNSAMPLE_W-1:0] downsample_q;
   logic [TRIG_LEVEL_W-1:0] trig_level_q;

   logic                    wr_en;
   logic                    addr_hit;
   logic [APB_DATA_W-1:0]   rd_data;

   assign wr_en = psel_i & penable_i & pwrite_i; // write lands at end of access phase

   always_comb begin
      addr_hit = 1'b1;
      rd_data  = '0;
      case (paddr_i)
         GAIN_ADDR:              rd_data = APB_DATA_W'(gain_q);
         SETTINGS_ADDR:          rd_data = APB_DATA_W'(settings_q);
         ECHO_ADDR:              rd_data = echo_q;
         SAMPLES_ADDR:           rd_data = APB_DATA_W'(samples_q);
         PRESAMPLES_ADDR:        rd_data = APB_DATA_W'(presamples_q);
         OFFSET_ADDR:            rd_data = offset_q;
         DECIMATE_ADDR:          rd_data = APB_DATA_W'(downsample_q);
         ADC_TRIG_LEVEL_ADDR:    rd_data = APB_DATA_W'(trig_level_q);
         MAX_SAMPLES_ADDR:       rd_data = APB_DATA_W'(MAX_SAMPLES);
         NUM_TRIGGERS_DATA_ADDR: rd_data = APB_DATA_W'(fifo_rdata_i);
         NUM_TRIGGERS_STAT_ADDR: begin
            rd_data = {{(APB_DATA_W-3){1'b0}}, fifo_underflow_i, fifo_overflow_i, fifo_empty_i};
         end
         default:                addr_hit = 1'b0;
      endcase
   end

   assign prdata_o  = (psel_i & ~pwrite_i) ? rd_data : '0;
   assign pready_o  = 1'b1; // no wait states
   assign pslverr_o = psel_i & penable_i & ~addr_hit;

   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         gain_q       <= '0;
         settings_q   <= SETTINGS_RESET;
         echo_q       <= '0;
         samples_q    <= MAX_SAMPLES;
         presamples_q <= '0;
         offset_q     <= '0;
         downsample_q <= '0;
         trig_level_q <= '0;
      end else if (wr_en) begin
         case (paddr_i)
            GAIN_ADDR:           gain_q       <= pwdata_i[GAIN_W-1:0];
            SETTINGS_ADDR:       settings_q   <= pwdata_i[7:0];
            ECHO_ADDR:           echo_q       <= pwdata_i;
            SAMPLES_ADDR:        samples_q    <= pwdata_i[SAMPLES_W-1:0];
            PRESAMPLES_ADDR:     presamples_q <= pwdata_i[PRESAMPLES_W-1:0];
            OFFSET_ADDR:         offset_q     <= pwdata_i;
            DECIMATE_ADDR:       downsample_q <= pwdata_i[DOWNSAMPLE_W-1:0];
            ADC_TRIG_LEVEL_ADDR: trig_level_q <= pwdata_i[TRIG_LEVEL_W-1:0];
            default: ; // max samples is fixed, fifo addresses handled below
         endcase
      end
   end

   // fifo command pulses, high for the cycle after the write
   always_ff @(posedge adc_sampleclk) begin
      if (reset) begin
         fifo_pop_o   <= 1'b0;
         fifo_clear_o <= 1'b0;
      end else begin
         fifo_pop_o   <= wr_en & (paddr_i == NUM_TRIGGERS_DATA_ADDR);
         fifo_clear_o <= wr_en & (paddr_i == NUM_TRIGGERS_STAT_ADDR);
      end
   end

   assign gain_o             = gain_q;
   assign trigger_mode_o     = settings_q[SET_TRIG_MODE_BIT];
   assign cmd_arm_o          = settings_q[SET_ARM_BIT];
   assign fifo_stream_o      = settings_q[SET_STREAM_BIT];
   assign trigger_wait_o     = settings_q[SET_TRIG_WAIT_BIT];
   assign trigger_now_o      = settings_q[SET_TRIG_NOW_BIT];
   assign trigger_offset_o   = offset_q;
   assign trigger_adclevel_o = trig_level_q;
   assign maxsamples_o       = samples_q;
   assign presamples_o       = presamples_q;
   assign downsample_o       = downsample_q;

endmodule

`default_nettype wire

/* logic/openadc_ctrl_top.sv */
`default_nettype none

module openadc_ctrl_top import openadc_pkg::*; (
   input  wire                      adc_sampleclk,
   input  wire                      reset,
   input  wire                      psel_i,
   input  wire                      penable_i,
   input  wire                      pwrite_i,
   input  wire  [APB_ADDR_W-1:0]    paddr_i,
   input  wire  [APB_DATA_W-1:0]    pwdata_i,
   output logic [APB_DATA_W-1:0]    prdata_o,
   output logic                     pready_o,
   output logic                     pslverr_o,
   input  wire                      trigger_event_i,
   output logic [GAIN_W-1:0]        gain_o,
   output logic                     trigger_mode_o,
   output logic                     cmd_arm_o,
   output logic                     fifo_stream_o,
   output logic                     trigger_wait_o,
   output logic                     trigger_now_o,
   output logic [APB_DATA_W-1:0]    trigger_offset_o,
   output logic [TRIG_LEVEL_W-1:0]  trigger_adclevel_o,
   output logic [SAMPLES_W-1:0]     maxsamples_o,
   output logic [PRESAMPLES_W-1:0]  presamples_o,
   output logic [DOWNSAMPLE_W-1:0]  downsample_o
);

   logic [TRIG_FIFO_WIDTH-1:0] fifo_rdata;
   logic [TRIG_FIFO_WIDTH-1:0] push_data;
   logic                       fifo_empty;
   logic                       fifo_full;
   logic                       fifo_overflow;
   logic                       fifo_underflow;
   logic                       fifo_pop;
   logic                       fifo_clear;
   logic                       push;
   logic                       flush_pop;

   openadc_reg_apb u_reg (
      .adc_sampleclk      (adc_sampleclk),
      .reset              (reset),
      .psel_i             (psel_i),
      .penable_i          (penable_i),
      .pwrite_i           (pwrite_i),
      .paddr_i            (paddr_i),
      .pwdata_i           (pwdata_i),
      .prdata_o           (prdata_o),
      .pready_o           (pready_o),
      .pslverr_o          (pslverr_o),
      .fifo_rdata_i       (fifo_rdata),
      .fifo_empty_i       (fifo_empty),
      .fifo_overflow_i    (fifo_overflow),
      .fifo_underflow_i   (fifo_underflow),
      .fifo_pop_o         (fifo_pop),
      .fifo_clear_o       (fifo_clear),
      .gain_o             (gain_o),
      .trigger_mode_o     (trigger_mode_o),
      .cmd_arm_o          (cmd_arm_o),
      .fifo_stream_o      (fifo_stream_o),
      .trigger_wait_o     (trigger_wait_o),
      .trigger_now_o      (trigger_now_o),
      .trigger_offset_o   (trigger_offset_o),
      .trigger_adclevel_o (trigger_adclevel_o),
      .maxsamples_o       (maxsamples_o),
      .presamples_o       (presamples_o),
      .downsample_o       (downsample_o)
   );

   trig_interval_logger u_logger (
      .adc_sampleclk   (adc_sampleclk),
      .reset           (reset),
      .trigger_event_i (trigger_event_i),
      .arm_i           (cmd_arm_o),
      .fifo_clear_i    (fifo_clear),
      .fifo_full_i     (fifo_full),
      .fifo_empty_i    (fifo_empty),
      .push_o          (push),
      .push_data_o     (push_data),
      .flush_pop_o     (flush_pop),
      .overflow_o      (fifo_overflow)
   );

   trig_interval_fifo #(
      .depth_p (TRIG_FIFO_DEPTH)
   ) u_fifo (
      .adc_sampleclk (adc_sampleclk),
      .reset         (reset),
      .push_i        (push),
      .push_data_i   (push_data),
      .pop_i         (fifo_pop),
      .flush_pop_i   (flush_pop),
      .clear_i       (fifo_clear),
      .rdata_o       (fifo_rdata),
      .full_o        (fifo_full),
      .empty_o       (fifo_empty),
      .underflow_o   (fifo_underflow)
   );

endmodule

`default_nettype wire

/* tb/openadc_ctrl_tb.sv */
`default_nettype none

module openadc_ctrl_tb import openadc_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned MAX_WORDS    = 256;
   localparam int unsigned BUS_TIMEOUT  = 16;
   localparam int unsigned POLL_TIMEOUT = 64;

   logic                    adc_sampleclk;
   logic                    reset;
   logic                    psel_i;
   logic                    penable_i;
   logic                    pwrite_i;
   logic [APB_ADDR_W-1:0]   paddr_i;
   logic [APB_DATA_W-1:0]   pwdata_i;
   logic [APB_DATA_W-1:0]   prdata_o;
   logic                    pready_o;
   logic                    pslverr_o;
   logic                    trigger_event_i;
   logic [GAIN_W-1:0]       gain_o;
   logic                    trigger_mode_o;
   logic                    cmd_arm_o;
   logic                    fifo_stream_o;
   logic                    trigger_wait_o;
   logic                    trigger_now_o;
   logic [APB_DATA_W-1:0]   trigger_offset_o;
   logic [TRIG_LEVEL_W-1:0] trigger_adclevel_o;
   logic [SAMPLES_W-1:0]    maxsamples_o;
   logic [PRESAMPLES_W-1:0] presamples_o;
   logic [DOWNSAMPLE_W-1:0] downsample_o;

   logic [31:0] stim [MAX_WORDS];
   logic [31:0] lfsr_q;
   logic [31:0] model_q [$]; // intervals the fifo should hold
   int unsigned edge_cnt = 0;
   int unsigned prev_edge;
   int unsigned errors = 0;
   int unsigned checks = 0;
   int unsigned tests  = 0;
   bit          step_err;

   openadc_ctrl_top dut_i (.*);

   initial begin
      adc_sampleclk = 1'b0;
      forever #10 adc_sampleclk = ~adc_sampleclk;
   end

   always @(posedge adc_sampleclk) edge_cnt <= edge_cnt + 1; // edge index for interval math

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   // control outputs that mirror a register placed as in its read word
   function automatic logic [31:0] port_value(input logic [7:0] addr);
      case (addr)
         GAIN_ADDR:           return 32'(gain_o);
         SETTINGS_ADDR: begin
            return {25'b0, trigger_now_o, trigger_wait_o, fifo_stream_o,
                    cmd_arm_o, trigger_mode_o, 2'b00};
         end
         SAMPLES_ADDR:        return maxsamples_o;
         PRESAMPLES_ADDR:     return 32'(presamples_o);
         OFFSET_ADDR:         return trigger_offset_o;
         DECIMATE_ADDR:       return 32'(downsample_o);
         ADC_TRIG_LEVEL_ADDR: return 32'(trigger_adclevel_o);
         default:             return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] port_mask(input logic [7:0] addr);
      case (addr)
         GAIN_ADDR:           return 32'h0000_00FF;
         SETTINGS_ADDR:       return 32'h0000_007C; // bits 2 to 6 leave the block
         SAMPLES_ADDR:        return 32'hFFFF_FFFF;
         PRESAMPLES_ADDR:     return 32'h0000_7FFF;
         OFFSET_ADDR:         return 32'hFFFF_FFFF;
         DECIMATE_ADDR:       return 32'h0000_1FFF;
         ADC_TRIG_LEVEL_ADDR: return 32'h0000_0FFF;
         default:             return 32'h0;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         errors++;
         step_err = 1'b1;
      end
   endtask

   // one apb transfer starting and ending 2 ns after a rising edge
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int unsigned waited;
      waited    = 0;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(posedge adc_sampleclk);
      #2;
      penable_i = 1'b1;
      #6;
      check_value(32'(pready_o), 32'h1, "ready in first access cycle");
      while (!pready_o) begin
         waited++;
         if (waited > BUS_TIMEOUT)
            abort_run("APB access got no ready response in time");
         @(posedge adc_sampleclk);
         #8;
      end
      rdata = prdata_o; // sampled mid-cycle away from the edge
      err   = pslverr_o;
      @(posedge adc_sampleclk);
      #2;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic drive_events(input int unsigned base, input int unsigned count);
      int unsigned gap;
      int unsigned sample;
      logic [2:0]  extra;
      for (int unsigned i = 0; i < count; i++) begin
         trigger_event_i = 1'b1;
         sample = edge_cnt + 1; // edge that samples this event
         if (model_q.size() < TRIG_FIFO_DEPTH)
            model_q.push_back(sample - prev_edge - 1);
         prev_edge = sample;
         @(posedge adc_sampleclk);
         #2;
         trigger_event_i = 1'b0;
         extra = '0;
         repeat (3) begin
            lfsr_q = lfsr_step(lfsr_q);
            extra  = {extra[1:0], lfsr_q[0]};
         end
         gap = base + extra;
         if (i + 1 < count) begin
            repeat (gap - 1) begin
               @(posedge adc_sampleclk);
               #2;
            end
         end
      end
   endtask

   task automatic pop_and_check();
      logic [31:0] rd;
      logic [31:0] exp;
      logic        err;
      apb_access(1'b1, NUM_TRIGGERS_DATA_ADDR, 32'h0, rd, err);
      apb_access(1'b0, NUM_TRIGGERS_DATA_ADDR, 32'h0, rd, err);
      if (model_q.size() == 0) begin
         $display("pop requested but no logged interval is expected");
         errors++;
         step_err = 1'b1;
      end else begin
         exp = model_q.pop_front();
         check_value(rd, exp, "logged interval");
      end
   endtask

   task automatic wait_flush_done();
      int unsigned polls;
      logic [31:0] rd;
      logic        err;
      polls = 0;
      rd    = '0;
      while (!rd[0]) begin
         if (polls >= POLL_TIMEOUT)
            abort_run("FIFO did not drain after arm within the poll limit");
         polls++;
         apb_access(1'b0, NUM_TRIGGERS_STAT_ADDR, 32'h0, rd, err);
      end
   endtask

   initial begin
      int unsigned n_lines;
      logic [31:0] op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic [31:0] rd;
      logic [31:0] mask;
      logic        err;
      psel_i          = 1'b0;
      penable_i       = 1'b0;
      pwrite_i        = 1'b0;
      paddr_i         = '0;
      pwdata_i        = '0;
      trigger_event_i = 1'b0;
      reset           = 1'b1;
      lfsr_q          = 32'h5388a991;
      $readmemh("tb/openadc_input.txt", stim);
      n_lines = 0;
      while (n_lines < MAX_WORDS / 4 && !$isunknown(stim[4 * n_lines]))
         n_lines++;
      if (n_lines == 0)
         abort_run("stimulus file tb/openadc_input.txt is missing or empty");
      repeat (4) @(posedge adc_sampleclk);
      #2;
      reset     = 1'b0;
      prev_edge = edge_cnt; // counter restarts from the last reset edge
      for (int unsigned idx = 0; idx < n_lines; idx++) begin
         op       = stim[4 * idx];
         addr     = stim[4 * idx + 1][7:0];
         data     = stim[4 * idx + 2];
         exp      = stim[4 * idx + 3];
         mask     = port_mask(addr);
         step_err = 1'b0;
         case (op)
            32'd0, 32'd1: begin
               apb_access(1'b1, addr, data, rd, err);
               check_value(32'(err), 32'h0, $sformatf("write response at %h", addr));
               if (mask != 0)
                  check_value(port_value(addr) & mask, exp & mask, "control output after write");
               if (op == 32'd1) begin
                  apb_access(1'b0, addr, 32'h0, rd, err);
                  check_value(rd, exp, $sformatf("readback of %h", addr));
               end
            end
            32'd2: begin
               apb_access(1'b0, addr, 32'h0, rd, err);
               check_value(32'(err), 32'h0, $sformatf("read response at %h", addr));
               check_value(rd, exp, $sformatf("read of %h", addr));
               if (mask != 0)
                  check_value(port_value(addr) & mask, exp & mask, "control output");
            end
            32'd3: drive_events(data, exp);
            32'd4: repeat (data) pop_and_check();
            32'd5: begin
               apb_access(1'b1, SETTINGS_ADDR, data, rd, err);
               check_value(32'(cmd_arm_o), 32'h1, "arm output after settings write");
               wait_flush_done();
               model_q.delete(); // flushed entries are gone
            end
            32'd6: begin
               apb_access(1'b0, addr, 32'h0, rd, err);
               check_value(32'(err), exp, $sformatf("bus error at %h", addr));
            end
            default: begin
               $display("stimulus line %0d has an unknown operation %h", idx, op);
               errors++;
               step_err = 1'b1;
            end
         endcase
         tests++;
         $display("test %0d op %0h at %0t ns: %s", idx, op, $time, step_err ? "error" : "ok");
      end
      $display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* openadc_ctrl.f */
logic/openadc_pkg.sv
logic/trig_interval_fifo.sv
logic/trig_interval_logger.sv
logic/openadc_reg_apb.sv
logic/openadc_ctrl_top.sv
tb/openadc_ctrl_tb.sv

/* Bender.yml */
package:
  name: openadc_ctrl

sources:
  - logic/openadc_pkg.sv
  - logic/trig_interval_fifo.sv
  - logic/trig_interval_logger.sv
  - logic/openadc_reg_apb.sv
  - logic/openadc_ctrl_top.sv
  - target: test
    files:
      - tb/openadc_ctrl_tb.sv

/* tb/openadc_input.txt */
// columns: op addr data expected, all hex
// op 0 write, 1 write and read back, 2 read, 3 events (data base gap, expected count), 4 pops (data count), 5 arm, 6 bus error
// reset values
2 00 00000000 00000000
2 04 00000000 00000024
2 08 00000000 00000000
2 0C 00000000 00006000
2 10 00000000 00000000
2 14 00000000 00000000
2 18 00000000 00000000
2 1C 00000000 00000000
2 20 00000000 00006000
2 24 00000000 00000000
2 28 00000000 00000001
// write and read back, masked to field width
1 00 001234A5 000000A5
1 04 FFFFFF7B 0000007B
1 04 00000024 00000024
1 08 CAFEF00D CAFEF00D
1 0C 00001000 00001000
1 10 FFFFFFFF 00007FFF
1 14 89ABCDEF 89ABCDEF
1 18 0000ABCD 00000BCD
1 1C DEADBEEF 00000EEF
// unmapped address and read-only word
6 2C 00000000 00000001
1 20 12345678 00006000
// interval logging
3 00 00000001 00000005
4 24 00000005 00000000
2 28 00000000 00000001
// overflow, underflow and clear
3 00 00000002 00000009
2 28 00000000 00000002
4 24 00000008 00000000
2 28 00000000 00000003
0 24 00000000 00000000
2 28 00000000 00000007
0 28 00000000 00000000
2 28 00000000 00000001
// flush on arm
3 00 00000003 00000008
2 28 00000000 00000000
5 04 0000002C 00000000
2 28 00000000 00000001
